//--- verilog/pov_pkg.sv
package pov_pkg;

  // Field widths on the SPI link
  localparam int POV_POS_BITS = 15;
  localparam int POV_DIR_BITS = 11;

  // Renderer fixed-point width, SQ10.10 with sign bit
  localparam int POV_WIDE_BITS = 21;

  // One SPI frame carries two positions and four direction components
  localparam int POV_FRAME_BITS = 2 * POV_POS_BITS + 4 * POV_DIR_BITS;

  // UQ6.9 player coordinate, range [0,64) in steps of 1/512
  typedef logic [POV_POS_BITS-1:0] posFix_t;

  // SQ2.9 direction component, range [-2,2) in steps of 1/512
  typedef logic [POV_DIR_BITS-1:0] dirFix_t;

  // SQ10.10 value as consumed by the renderer
  typedef logic [POV_WIDE_BITS-1:0] wideFix_t;

  // Field order matches the wire order, first field arrives first
  typedef struct packed {
    posFix_t playerX;
    posFix_t playerY;
    dirFix_t facingX;
    dirFix_t facingY;
    dirFix_t vplaneX;
    dirFix_t vplaneY;
  } povPose_t;

  // Live pose after widening to renderer format
  typedef struct packed {
    wideFix_t playerX;
    wideFix_t playerY;
    wideFix_t facingX;
    wideFix_t facingY;
    wideFix_t vplaneX;
    wideFix_t vplaneY;
  } povWide_t;

  // Demo start pose, each value times 512 truncated toward zero
  // Player at (11.5, 10.5), facing (0.720137, -0.693832)
  // View plane (0.346916, 0.360069)
  localparam povPose_t POV_RESET_POSE = '{
    playerX: posFix_t'(5888),
    playerY: posFix_t'(5376),
    facingX: dirFix_t'(368),
    facingY: dirFix_t'(-355),
    vplaneX: dirFix_t'(177),
    vplaneY: dirFix_t'(184)
  };

endpackage

//--- verilog/spiFrameReceiver.sv
`timescale 1ns/1ps

module spiFrameReceiver
  import pov_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     i_sclk,
  input  logic     i_ssN,
  input  logic     i_mosi,
  output logic     o_frameValid,
  output povPose_t o_frame
);

  // Bit counter covers 0 to 73
  localparam int CNT_BITS = $clog2(POV_FRAME_BITS);
  localparam logic [CNT_BITS-1:0] LAST_BIT = CNT_BITS'(POV_FRAME_BITS - 1);

  // Three stages on SCLK so the top two give the edge
  logic [2:0] sclkSync;
  logic [1:0] ssNSync;
  logic [1:0] mosiSync;

  logic sclkRise;
  logic ssActive;
  logic mosiBit;
  logic frameEnd;

  logic [CNT_BITS-1:0] bitCount;
  // Last bit of a frame goes straight into frameReg
  logic [POV_FRAME_BITS-2:0] shiftReg;
  povPose_t frameReg;

  // Control pin synchronizers, idle SPI state on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      sclkSync <= '0;
      ssNSync <= '1;
    end else begin
      sclkSync <= {sclkSync[1:0], i_sclk};
      ssNSync <= {ssNSync[0], i_ssN};
    end
  end

  // Two flops on MOSI, the bit is used only on an SCLK edge
  always_ff @(posedge clk) begin
    mosiSync <= {mosiSync[0], i_mosi};
  end

  assign sclkRise = ~sclkSync[2] & sclkSync[1];
  assign ssActive = ~ssNSync[1];
  assign mosiBit = mosiSync[1];
  assign frameEnd = (bitCount == LAST_BIT);

  // Counter wraps so frames can run back to back under one SS_N
  // SS_N high discards a partial frame
  always_ff @(posedge clk) begin
    if (reset || !ssActive) begin
      bitCount <= '0;
    end else if (sclkRise) begin
      bitCount <= frameEnd ? '0 : bitCount + 1'b1;
    end
  end

  // MSB first, so older bits move up
  always_ff @(posedge clk) begin
    if (ssActive && sclkRise) begin
      shiftReg <= {shiftReg[POV_FRAME_BITS-3:0], mosiBit};
      // Hold the complete frame until the next one ends
      if (frameEnd) begin
        frameReg <= {shiftReg, mosiBit};
      end
    end
  end

  // One-cycle pulse alongside the new frameReg
  always_ff @(posedge clk) begin
    if (reset) begin
      o_frameValid <= 1'b0;
    end else begin
      o_frameValid <= ssActive & sclkRise & frameEnd;
    end
  end

  assign o_frame = frameReg;

endmodule

//--- verilog/frameTicker.sv
`timescale 1ns/1ps

module frameTicker #(
  parameter int FRAME_CYCLES = 200
) (
  input  logic clk,
  input  logic reset,
  output logic o_tick
);

  // Keep at least one counter bit for very short frames
  localparam int CNT_BITS = (FRAME_CYCLES > 1) ? $clog2(FRAME_CYCLES) : 1;
  localparam logic [CNT_BITS-1:0] LAST_CYCLE = CNT_BITS'(FRAME_CYCLES - 1);

  logic [CNT_BITS-1:0] cycleCount;

  // Free-running frame counter
  always_ff @(posedge clk) begin
    if (reset) begin
      cycleCount <= '0;
    end else if (cycleCount == LAST_CYCLE) begin
      cycleCount <= '0;
    end else begin
      cycleCount <= cycleCount + 1'b1;
    end
  end

  // Last cycle of each frame, safe point for a pose change
  assign o_tick = (cycleCount == LAST_CYCLE);

endmodule

//--- verilog/povRegisters.sv
`timescale 1ns/1ps

module povRegisters
  import pov_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     i_frameValid,
  input  povPose_t i_frame,
  input  logic     i_tick,
  input  logic     i_nudgeX,
  input  logic     i_nudgeY,
  output povWide_t o_pose,
  output logic     o_poseLoaded
);

  // Zero padding above a position, sign bit fills the gap for directions
  localparam int POS_PAD = POV_WIDE_BITS - POV_POS_BITS - 1;
  localparam int DIR_PAD = POV_WIDE_BITS - POV_DIR_BITS;

  // Last complete frame, waiting for a tick
  povPose_t pendingFrame;
  logic pendingValid;

  // Pose the renderer currently sees
  povPose_t livePose;

  logic nudgeActive;
  logic applyNudge;
  logic applyLoad;

  // Nudge wins over a pending load
  assign nudgeActive = i_nudgeX | i_nudgeY;
  assign applyNudge = i_tick & nudgeActive;
  assign applyLoad = i_tick & ~nudgeActive & pendingValid;

  // Newest frame overwrites an older one
  always_ff @(posedge clk) begin
    if (i_frameValid) begin
      pendingFrame <= i_frame;
    end
  end

  // A nudge in the same cycle cancels the arriving frame too
  always_ff @(posedge clk) begin
    if (reset) begin
      pendingValid <= 1'b0;
    end else if (i_frameValid) begin
      pendingValid <= ~applyNudge;
    end else if (i_tick) begin
      pendingValid <= 1'b0;
    end
  end

  // Live pose only moves on a tick
  always_ff @(posedge clk) begin
    if (reset) begin
      livePose <= POV_RESET_POSE;
    end else if (applyNudge) begin
      // Step down one LSB, wraps from 0 to all ones
      if (i_nudgeX) begin
        livePose.playerX <= livePose.playerX - posFix_t'(1);
      end
      if (i_nudgeY) begin
        livePose.playerY <= livePose.playerY - posFix_t'(1);
      end
    end else if (applyLoad) begin
      livePose <= pendingFrame;
    end
  end

  // Pulse lines up with the new value on o_pose
  always_ff @(posedge clk) begin
    if (reset) begin
      o_poseLoaded <= 1'b0;
    end else begin
      o_poseLoaded <= applyNudge | applyLoad;
    end
  end

  // UQ6.9 to SQ10.10, position is never negative
  function automatic wideFix_t widenPos(input posFix_t pos);
    return {{POS_PAD{1'b0}}, pos, 1'b0};
  endfunction

  // SQ2.9 to SQ10.10 by sign extension
  function automatic wideFix_t widenDir(input dirFix_t dir);
    return {{DIR_PAD{dir[POV_DIR_BITS-1]}}, dir[POV_DIR_BITS-2:0], 1'b0};
  endfunction

  // Renderer samples these every cycle
  assign o_pose.playerX = widenPos(livePose.playerX);
  assign o_pose.playerY = widenPos(livePose.playerY);
  assign o_pose.facingX = widenDir(livePose.facingX);
  assign o_pose.facingY = widenDir(livePose.facingY);
  assign o_pose.vplaneX = widenDir(livePose.vplaneX);
  assign o_pose.vplaneY = widenDir(livePose.vplaneY);

endmodule

//--- verilog/povTop.sv
`timescale 1ns/1ps

module povTop
  import pov_pkg::*;
#(
  parameter int FRAME_CYCLES = 200
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     i_sclk,
  input  logic     i_ssN,
  input  logic     i_mosi,
  input  logic     i_nudgeX,
  input  logic     i_nudgeY,
  output povWide_t o_pose,
  output logic     o_poseLoaded,
  output logic     o_frameTick
);

  // Receiver to register bank
  logic frameValid;
  povPose_t frame;

  // Frame-end tick, shared with the output
  logic frameTick;

  spiFrameReceiver u_receiver (
    .clk          (clk),
    .reset        (reset),
    .i_sclk       (i_sclk),
    .i_ssN        (i_ssN),
    .i_mosi       (i_mosi),
    .o_frameValid (frameValid),
    .o_frame      (frame)
  );

  // Stands in for the video timing
  frameTicker #(
    .FRAME_CYCLES (FRAME_CYCLES)
  ) u_ticker (
    .clk    (clk),
    .reset  (reset),
    .o_tick (frameTick)
  );

  povRegisters u_registers (
    .clk          (clk),
    .reset        (reset),
    .i_frameValid (frameValid),
    .i_frame      (frame),
    .i_tick       (frameTick),
    .i_nudgeX     (i_nudgeX),
    .i_nudgeY     (i_nudgeY),
    .o_pose       (o_pose),
    .o_poseLoaded (o_poseLoaded)
  );

  assign o_frameTick = frameTick;

endmodule

//--- test/povTop_properties.sv
`timescale 1ns/1ps

module povTop_properties
  import pov_pkg::*;
(
  input logic     clk,
  input logic     reset,
  input logic     i_frameValid,
  input logic     i_tick,
  input logic     o_poseLoaded,
  input povWide_t o_pose
);

  // Failure count, read by the testbench at the end of the run
  int assertFailures = 0;

  // Load pulse follows a tick by exactly one cycle
  assert property (@(posedge clk) disable iff (reset) o_poseLoaded |-> $past(i_tick))
    else begin
      assertFailures++;
      $error("o_poseLoaded was high without a tick in the previous cycle");
    end

  // Frame valid is a single-cycle pulse
  assert property (@(posedge clk) disable iff (reset) i_frameValid |=> !i_frameValid)
    else begin
      assertFailures++;
      $error("i_frameValid stayed high for two cycles");
    end

  // Renderer never sees a change in the middle of a frame
  assert property (@(posedge clk) disable iff (reset) !$past(i_tick) |-> $stable(o_pose))
    else begin
      assertFailures++;
      $error("o_pose changed in a cycle that did not follow a tick");
    end

endmodule

bind povRegisters povTop_properties u_properties (.*);

//--- test/povTop_tb.sv
`timescale 1ns/1ps

module povTop_tb
  import pov_pkg::*;
();

  localparam int FRAME_CYCLES = 200;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_ROWS = 8;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_ROWS * (2 * POV_FRAME_BITS * 8 + 400);

  // One scenario row, frames go out in this order
  typedef struct packed {
    logic     abortFirst;
    logic [1:0] numFrames;
    povPose_t partialFrame;
    povPose_t frameA;
    povPose_t frameB;
    logic     nudgeX;
    logic     nudgeY;
    povPose_t expPose;
    logic [1:0] expLoads;
  } scenario_t;

  logic clk = 1'b0;
  logic reset;
  logic sclk;
  logic ssN;
  logic mosi;
  logic nudgeX;
  logic nudgeY;
  povWide_t pose;
  logic poseLoaded;
  logic frameTick;

  scenario_t scenarios [NUM_ROWS];
  logic [31:0] rngState = 32'h4cc4_42c3;
  int loadCount = 0;

  // Cycles since reset release or the previous tick
  int tickGap = 0;

  povTop #(
    .FRAME_CYCLES (FRAME_CYCLES)
  ) DUT (
    .clk          (clk),
    .reset        (reset),
    .i_sclk       (sclk),
    .i_ssN        (ssN),
    .i_mosi       (mosi),
    .i_nudgeX     (nudgeX),
    .i_nudgeY     (nudgeY),
    .o_pose       (pose),
    .o_poseLoaded (poseLoaded),
    .o_frameTick  (frameTick)
  );

  always #5 clk = ~clk;

  // Running total of load pulses
  always @(posedge clk) begin
    if (poseLoaded) begin
      loadCount <= loadCount + 1;
    end
  end

  // Tick is a single-cycle pulse every FRAME_CYCLES cycles
  always @(negedge clk) begin
    if (reset) begin
      tickGap = 0;
    end else begin
      tickGap = tickGap + 1;
      if (frameTick) begin
        assert (tickGap == FRAME_CYCLES) else begin
          $display("FAILED time=%0t o_frameTick period expected=%0d got=%0d",
                   $time, FRAME_CYCLES, tickGap);
          stopOnFailure();
        end
        tickGap = 0;
      end
    end
  end

  // Stop at the first failed bound property
  always @(negedge clk) begin
    assert (DUT.u_registers.u_properties.assertFailures == 0) else begin
      $display("A bound property on the register bank failed, see the error above");
      stopOnFailure();
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic drawRandom(output logic [31:0] value);
    rngState = xorshift32(rngState);
    value = rngState;
  endtask

  task automatic makeRandomPose(output povPose_t p);
    logic [31:0] r;
    drawRandom(r);
    p.playerX = r[14:0];
    p.playerY = r[30:16];
    drawRandom(r);
    p.facingX = r[10:0];
    p.facingY = r[26:16];
    drawRandom(r);
    p.vplaneX = r[10:0];
    p.vplaneY = r[26:16];
  endtask

  // Position is unsigned, so a plain shift into the SQ10.10 grid
  function automatic wideFix_t positionToWide(input posFix_t value);
    return wideFix_t'(value) << 1;
  endfunction

  // Direction keeps its sign through the shift
  function automatic wideFix_t directionToWide(input dirFix_t value);
    logic signed [POV_WIDE_BITS-1:0] extended;
    extended = $signed(value);
    return wideFix_t'(extended <<< 1);
  endfunction

  function automatic povWide_t expandPose(input povPose_t p);
    povWide_t w;
    w.playerX = positionToWide(p.playerX);
    w.playerY = positionToWide(p.playerY);
    w.facingX = directionToWide(p.facingX);
    w.facingY = directionToWide(p.facingY);
    w.vplaneX = directionToWide(p.vplaneX);
    w.vplaneY = directionToWide(p.vplaneY);
    return w;
  endfunction

  task automatic stopOnFailure();
    $display("Finished with errors");
    $fatal(1, "Stopping at the first failed check");
  endtask

  task automatic checkValue(input string name, input wideFix_t got, input wideFix_t exp);
    assert (got === exp) else begin
      $display("FAILED time=%0t %s expected=%h got=%h", $time, name, exp, got);
      stopOnFailure();
    end
  endtask

  task automatic checkPose(input povWide_t exp);
    checkValue("o_pose.playerX", pose.playerX, exp.playerX);
    checkValue("o_pose.playerY", pose.playerY, exp.playerY);
    checkValue("o_pose.facingX", pose.facingX, exp.facingX);
    checkValue("o_pose.facingY", pose.facingY, exp.facingY);
    checkValue("o_pose.vplaneX", pose.vplaneX, exp.vplaneX);
    checkValue("o_pose.vplaneY", pose.vplaneY, exp.vplaneY);
  endtask

  // Tick is seen at the falling edge of its cycle
  task automatic waitForTick();
    do begin
      @(negedge clk);
    end while (!frameTick);
  endtask

  task automatic openWindow();
    @(posedge clk);
    ssN <= 1'b0;
    repeat (3) @(posedge clk);
  endtask

  task automatic closeWindow();
    @(posedge clk);
    sclk <= 1'b0;
    repeat (3) @(posedge clk);
    @(posedge clk);
    ssN <= 1'b1;
    repeat (3) @(posedge clk);
  endtask

  // SCLK at clk/8, data changes on the falling half, MSB first
  task automatic sendBits(input povPose_t p, input int nBits);
    for (int i = 0; i < nBits; i++) begin
      @(posedge clk);
      sclk <= 1'b0;
      mosi <= p[POV_FRAME_BITS-1-i];
      repeat (3) @(posedge clk);
      @(posedge clk);
      sclk <= 1'b1;
      repeat (3) @(posedge clk);
    end
  endtask

  task automatic buildScenarios();
    povPose_t p;
    scenarios[0] = '0;
    scenarios[0].expPose = POV_RESET_POSE;
    // Single random frame
    scenarios[1] = '0;
    makeRandomPose(p);
    scenarios[1].numFrames = 2'd1;
    scenarios[1].frameA = p;
    scenarios[1].expPose = p;
    scenarios[1].expLoads = 2'd1;
    // Back to back frames, the first one lands on an earlier tick
    scenarios[2] = '0;
    scenarios[2].numFrames = 2'd2;
    makeRandomPose(p);
    scenarios[2].frameA = p;
    makeRandomPose(p);
    scenarios[2].frameB = p;
    scenarios[2].expPose = p;
    scenarios[2].expLoads = 2'd2;
    // 40-bit partial frame then a full one
    scenarios[3] = '0;
    scenarios[3].abortFirst = 1'b1;
    makeRandomPose(p);
    scenarios[3].partialFrame = p;
    scenarios[3].numFrames = 2'd1;
    makeRandomPose(p);
    scenarios[3].frameA = p;
    scenarios[3].expPose = p;
    scenarios[3].expLoads = 2'd1;
    // Nudge drops the pending frame and steps both coordinates
    scenarios[4] = '0;
    scenarios[4].numFrames = 2'd1;
    makeRandomPose(p);
    scenarios[4].frameA = p;
    scenarios[4].nudgeX = 1'b1;
    scenarios[4].nudgeY = 1'b1;
    scenarios[4].expPose = scenarios[3].expPose;
    scenarios[4].expPose.playerX = scenarios[3].expPose.playerX - posFix_t'(1);
    scenarios[4].expPose.playerY = scenarios[3].expPose.playerY - posFix_t'(1);
    scenarios[4].expLoads = 2'd1;
    // Quiet tick, nothing left pending
    scenarios[5] = '0;
    scenarios[5].expPose = scenarios[4].expPose;
    // Edge values, -2.0 and -1/512 on the facing vector
    scenarios[6] = '0;
    makeRandomPose(p);
    p.playerX = 15'h0000;
    p.facingX = 11'h400;
    p.facingY = 11'h7ff;
    p.vplaneY = 11'h3ff;
    scenarios[6].numFrames = 2'd1;
    scenarios[6].frameA = p;
    scenarios[6].expPose = p;
    scenarios[6].expLoads = 2'd1;
    // X at zero wraps to 63.998
    scenarios[7] = '0;
    scenarios[7].nudgeX = 1'b1;
    scenarios[7].expPose = p;
    scenarios[7].expPose.playerX = 15'h7fff;
    scenarios[7].expLoads = 2'd1;
  endtask

  task automatic runScenario(input int idx);
    scenario_t row;
    int startLoads;
    row = scenarios[idx];
    // Start each row at a known phase of the frame ticker
    waitForTick();
    startLoads = loadCount;
    repeat (100) @(posedge clk);
    if (row.abortFirst) begin
      openWindow();
      sendBits(row.partialFrame, 40);
      closeWindow();
    end
    if (row.numFrames != 0) begin
      openWindow();
      sendBits(row.frameA, POV_FRAME_BITS);
      if (row.numFrames > 1) begin
        sendBits(row.frameB, POV_FRAME_BITS);
      end
      closeWindow();
    end
    @(posedge clk);
    nudgeX <= row.nudgeX;
    nudgeY <= row.nudgeY;
    waitForTick();
    @(negedge clk);
    checkPose(expandPose(row.expPose));
    @(posedge clk);
    nudgeX <= 1'b0;
    nudgeY <= 1'b0;
    @(negedge clk);
    assert ((loadCount - startLoads) == int'(row.expLoads)) else begin
      $display("FAILED time=%0t o_poseLoaded pulses expected=%0d got=%0d",
               $time, row.expLoads, loadCount - startLoads);
      stopOnFailure();
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Finished with errors");
    $fatal(1, "Watchdog timeout, the scenario table did not complete in time");
  end

  initial begin
    reset = 1'b1;
    sclk = 1'b0;
    ssN = 1'b1;
    mosi = 1'b0;
    nudgeX = 1'b0;
    nudgeY = 1'b0;
    buildScenarios();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    checkPose(expandPose(POV_RESET_POSE));
    for (int i = 0; i < NUM_ROWS; i++) begin
      runScenario(i);
    end
    if (DUT.u_registers.u_properties.assertFailures == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- povTop.f
verilog/pov_pkg.sv
verilog/spiFrameReceiver.sv
verilog/frameTicker.sv
verilog/povRegisters.sv
verilog/povTop.sv
test/povTop_properties.sv
test/povTop_tb.sv
